/* qu_pkg.sv */
// ==============================
// Back-end widths, word typedefs
// and ALU opcode codes
// ==============================

package qu_pkg;

    // Field widths
    localparam int data_w     = 32;
    localparam int phy_addr_w = 6;
    localparam int rob_addr_w = 4;
    localparam int rs_idx_w   = 3;
    localparam int opcode_w   = 3;

    typedef logic [data_w-1:0]     data_t;
    typedef logic [phy_addr_w-1:0] phy_addr_t;
    typedef logic [rob_addr_w-1:0] rob_addr_t;
    typedef logic [rs_idx_w-1:0]   rs_idx_t;
    typedef logic [opcode_w-1:0]   opcode_t;

    // ALU operations
    localparam opcode_t OP_ADD = 3'd0;
    localparam opcode_t OP_SUB = 3'd1;
    localparam opcode_t OP_AND = 3'd2;
    localparam opcode_t OP_OR  = 3'd3;
    localparam opcode_t OP_XOR = 3'd4;
    localparam opcode_t OP_SLL = 3'd5;
    localparam opcode_t OP_SRL = 3'd6;
    localparam opcode_t OP_SLT = 3'd7;

    // Issued micro-op, MSB first: opcode, dest, src1 value, src2 value, rob index
    localparam int uop_w = opcode_w + phy_addr_w + 2 * data_w + rob_addr_w;

    // Field offsets inside an issued micro-op
    localparam int uop_rob_lsb  = 0;
    localparam int uop_s2_lsb   = uop_rob_lsb + rob_addr_w;
    localparam int uop_s1_lsb   = uop_s2_lsb + data_w;
    localparam int uop_dest_lsb = uop_s1_lsb + data_w;
    localparam int uop_op_lsb   = uop_dest_lsb + phy_addr_w;

    // Completion word: dest tag above the result
    localparam int done_w = phy_addr_w + data_w;

endpackage

/* fifo.sv */
// ==============================
// First-word-fall-through FIFO
// ==============================

`timescale 1ns/1ps

module fifo #(
    parameter int WIDTH       = 32,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] data_in,
    input  logic             rd_en,
    output logic [WIDTH-1:0] data_out,
    output logic             empty,
    output logic             full
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    logic [WIDTH-1:0] mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign do_wr    = wr_en && !full;
    assign do_rd    = rd_en && !empty;
    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(QUEUE_DEPTH));
    assign data_out = mem[rd_ptr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= data_in;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n) wr_en |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n) rd_en |-> !empty);

endmodule

/* res_station.sv */
// ==============================
// Reservation station entries,
// dispatch, wakeup and issue read
// ==============================

`timescale 1ns/1ps

module res_station import qu_pkg::*; #(
    parameter int RS_DEPTH = 8
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                dispatch_en,
    input  opcode_t             dispatch_op,
    input  phy_addr_t           dispatch_dest,
    input  rob_addr_t           dispatch_rob,
    input  data_t               dispatch_s1_val,
    input  logic                dispatch_s1_rdy,
    input  phy_addr_t           dispatch_s1_tag,
    input  data_t               dispatch_s2_val,
    input  logic                dispatch_s2_rdy,
    input  phy_addr_t           dispatch_s2_tag,
    input  logic                wb_en,
    input  phy_addr_t           wb_addr,
    input  data_t               wb_data,
    input  logic                issue_en,
    input  rs_idx_t             issue_idx,
    output logic                dispatch_ready,
    output logic [RS_DEPTH-1:0] ready_vec,
    output logic [uop_w-1:0]    issue_uop
);

    logic [RS_DEPTH-1:0] ent_valid;
    logic [RS_DEPTH-1:0] ent_s1_rdy;
    logic [RS_DEPTH-1:0] ent_s2_rdy;
    opcode_t             ent_op     [RS_DEPTH];
    phy_addr_t           ent_dest   [RS_DEPTH];
    rob_addr_t           ent_rob    [RS_DEPTH];
    data_t               ent_s1_val [RS_DEPTH];
    data_t               ent_s2_val [RS_DEPTH];
    phy_addr_t           ent_s1_tag [RS_DEPTH];
    phy_addr_t           ent_s2_tag [RS_DEPTH];

    logic [RS_DEPTH-1:0] s1_hit;
    logic [RS_DEPTH-1:0] s2_hit;
    logic                s1_fwd;
    logic                s2_fwd;
    rs_idx_t             free_idx;
    logic                dispatch_fire;

    // Lowest free slot takes the next dispatch
    always_comb begin
        free_idx       = '0;
        dispatch_ready = 1'b0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                free_idx       = rs_idx_t'(i);
                dispatch_ready = 1'b1;
            end
        end
    end

    // Tag match against the write-back bus
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            s1_hit[i] = wb_en && ent_valid[i] && !ent_s1_rdy[i] && (ent_s1_tag[i] == wb_addr);
            s2_hit[i] = wb_en && ent_valid[i] && !ent_s2_rdy[i] && (ent_s2_tag[i] == wb_addr);
        end
    end

    // Same-cycle wakeup of an incoming op
    assign s1_fwd        = wb_en && !dispatch_s1_rdy && (dispatch_s1_tag == wb_addr);
    assign s2_fwd        = wb_en && !dispatch_s2_rdy && (dispatch_s2_tag == wb_addr);
    assign dispatch_fire = dispatch_en && dispatch_ready;

    assign ready_vec = ent_valid & ent_s1_rdy & ent_s2_rdy;
    assign issue_uop = {ent_op[issue_idx], ent_dest[issue_idx], ent_s1_val[issue_idx],
                        ent_s2_val[issue_idx], ent_rob[issue_idx]};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ent_valid  <= '0;
            ent_s1_rdy <= '0;
            ent_s2_rdy <= '0;
        end else begin
            ent_s1_rdy <= ent_s1_rdy | s1_hit;
            ent_s2_rdy <= ent_s2_rdy | s2_hit;
            if (issue_en) begin
                ent_valid[issue_idx] <= 1'b0;
            end
            if (dispatch_fire) begin
                ent_valid[free_idx]  <= 1'b1;
                ent_s1_rdy[free_idx] <= dispatch_s1_rdy || s1_fwd;
                ent_s2_rdy[free_idx] <= dispatch_s2_rdy || s2_fwd;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (s1_hit[i]) begin
                ent_s1_val[i] <= wb_data;
            end
            if (s2_hit[i]) begin
                ent_s2_val[i] <= wb_data;
            end
        end
        if (dispatch_fire) begin
            ent_op[free_idx]     <= dispatch_op;
            ent_dest[free_idx]   <= dispatch_dest;
            ent_rob[free_idx]    <= dispatch_rob;
            ent_s1_tag[free_idx] <= dispatch_s1_tag;
            ent_s2_tag[free_idx] <= dispatch_s2_tag;
            ent_s1_val[free_idx] <= s1_fwd ? wb_data : dispatch_s1_val;
            ent_s2_val[free_idx] <= s2_fwd ? wb_data : dispatch_s2_val;
        end
    end

    a_no_dispatch_full: assert property (
        @(posedge clk) disable iff (!arst_n) dispatch_en |-> dispatch_ready);
    a_issue_ready: assert property (
        @(posedge clk) disable iff (!arst_n) issue_en |-> ready_vec[issue_idx]);

endmodule

/* schedule.sv */
// ==============================
// Round-robin issue scheduler
// ==============================

`timescale 1ns/1ps

module schedule import qu_pkg::*; #(
    parameter int RS_DEPTH = 8
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                schedule_en,
    input  logic [RS_DEPTH-1:0] ready_vec,
    input  logic                queue_full,
    output logic                issue_en,
    output rs_idx_t             issue_idx
);

    rs_idx_t prio_ptr;
    logic    pick_found;

    // First ready entry at or after the priority pointer
    always_comb begin
        issue_idx  = prio_ptr;
        pick_found = 1'b0;
        for (int k = 0; k < RS_DEPTH; k++) begin
            if (!pick_found && ready_vec[(int'(prio_ptr) + k) % RS_DEPTH]) begin
                pick_found = 1'b1;
                issue_idx  = rs_idx_t'((int'(prio_ptr) + k) % RS_DEPTH);
            end
        end
    end

    // Throttle while the issue queue cannot take a word
    assign issue_en = schedule_en && !queue_full && pick_found;

    // Move priority past the entry just issued
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prio_ptr <= '0;
        end else if (issue_en) begin
            if (int'(issue_idx) == RS_DEPTH - 1) begin
                prio_ptr <= '0;
            end else begin
                prio_ptr <= issue_idx + 1'b1;
            end
        end
    end

    a_issue_when_ready: assert property (
        @(posedge clk) disable iff (!arst_n)
        (schedule_en && !queue_full && (ready_vec != '0)) |-> issue_en);

endmodule

/* execute.sv */
// ==============================
// Integer ALU
// ==============================

`timescale 1ns/1ps

module execute import qu_pkg::*; (
    input  logic [uop_w-1:0] uop_in,
    output data_t            result,
    output phy_addr_t        dest
);

    opcode_t op;
    data_t   src_a;
    data_t   src_b;

    assign op    = uop_in[uop_op_lsb +: opcode_w];
    assign dest  = uop_in[uop_dest_lsb +: phy_addr_w];
    assign src_a = uop_in[uop_s1_lsb +: data_w];
    assign src_b = uop_in[uop_s2_lsb +: data_w];

    always_comb begin
        case (op)
            OP_ADD: result = src_a + src_b;
            OP_SUB: result = src_a - src_b;
            OP_AND: result = src_a & src_b;
            OP_OR:  result = src_a | src_b;
            OP_XOR: result = src_a ^ src_b;
            // Shift amount is the low 5 bits
            OP_SLL: result = src_a << src_b[4:0];
            OP_SRL: result = src_a >> src_b[4:0];
            OP_SLT: result = ($signed(src_a) < $signed(src_b)) ? data_t'(1) : '0;
            default: result = '0;
        endcase
    end

endmodule

/* retire.sv */
// ==============================
// Write-back register and ROB
// tail and occupancy counter
// ==============================

`timescale 1ns/1ps

module retire import qu_pkg::*; #(
    parameter int ROB_DEPTH = 16
) (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      valid,
    input  phy_addr_t dest,
    input  data_t     result,
    input  logic      rob_incr_tail_ptr,
    output logic      wb_en,
    output phy_addr_t wb_addr,
    output data_t     wb_data,
    output rob_addr_t rob_tail_ptr,
    output logic      rob_full
);

    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    logic [CNT_W-1:0] rob_count;
    logic             rob_fire;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_addr <= dest;
        wb_data <= result;
    end

    // Allocation is dropped once the ROB is full
    assign rob_fire = rob_incr_tail_ptr && !rob_full;
    assign rob_full = (rob_count == CNT_W'(ROB_DEPTH));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rob_tail_ptr <= '0;
            rob_count    <= '0;
        end else begin
            if (rob_fire) begin
                rob_tail_ptr <= (int'(rob_tail_ptr) == ROB_DEPTH - 1) ? '0 : rob_tail_ptr + 1'b1;
            end
            if (rob_fire && !wb_en) begin
                rob_count <= rob_count + 1'b1;
            end else if (wb_en && !rob_fire) begin
                rob_count <= rob_count - 1'b1;
            end
        end
    end

    a_rob_no_underflow: assert property (
        @(posedge clk) disable iff (!arst_n) wb_en |-> (rob_count != '0));

endmodule

/* qu_back_end.sv */
// ==============================
// Back-end top level
// ==============================

`timescale 1ns/1ps

module qu_back_end import qu_pkg::*; #(
    parameter int RS_DEPTH    = 8,
    parameter int QUEUE_DEPTH = 4,
    parameter int ROB_DEPTH   = 16
) (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      schedule_en,
    input  logic      dispatch_en,
    input  opcode_t   dispatch_op,
    input  phy_addr_t dispatch_dest,
    input  rob_addr_t dispatch_rob,
    input  data_t     dispatch_s1_val,
    input  logic      dispatch_s1_rdy,
    input  phy_addr_t dispatch_s1_tag,
    input  data_t     dispatch_s2_val,
    input  logic      dispatch_s2_rdy,
    input  phy_addr_t dispatch_s2_tag,
    input  logic      rob_incr_tail_ptr,
    output logic      dispatch_ready,
    output logic      wb_en,
    output phy_addr_t wb_addr,
    output data_t     wb_data,
    output rob_addr_t rob_tail_ptr,
    output logic      rob_full
);

    logic [RS_DEPTH-1:0] ready_vec;
    logic                issue_en;
    rs_idx_t             issue_idx;
    logic [uop_w-1:0]    issue_uop;

    logic                iq_empty;
    logic                iq_full;
    logic                iq_pop;
    logic [uop_w-1:0]    iq_head;

    data_t               exec_result;
    phy_addr_t           exec_dest;

    logic                dq_empty;
    logic                dq_full;
    logic [done_w-1:0]   dq_wr_data;
    logic [done_w-1:0]   dq_head;

    // Issue queue drains into the completion queue through the ALU
    assign iq_pop     = !iq_empty && !dq_full;
    assign dq_wr_data = {exec_dest, exec_result};

    res_station #(.RS_DEPTH(RS_DEPTH)) u_res_station (
        .clk(clk), .arst_n(arst_n),
        .dispatch_en(dispatch_en), .dispatch_op(dispatch_op),
        .dispatch_dest(dispatch_dest), .dispatch_rob(dispatch_rob),
        .dispatch_s1_val(dispatch_s1_val), .dispatch_s1_rdy(dispatch_s1_rdy),
        .dispatch_s1_tag(dispatch_s1_tag), .dispatch_s2_val(dispatch_s2_val),
        .dispatch_s2_rdy(dispatch_s2_rdy), .dispatch_s2_tag(dispatch_s2_tag),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data),
        .issue_en(issue_en), .issue_idx(issue_idx),
        .dispatch_ready(dispatch_ready), .ready_vec(ready_vec), .issue_uop(issue_uop)
    );

    schedule #(.RS_DEPTH(RS_DEPTH)) u_schedule (
        .clk(clk), .arst_n(arst_n), .schedule_en(schedule_en),
        .ready_vec(ready_vec), .queue_full(iq_full),
        .issue_en(issue_en), .issue_idx(issue_idx)
    );

    fifo #(.WIDTH(uop_w), .QUEUE_DEPTH(QUEUE_DEPTH)) u_issue_q (
        .clk(clk), .arst_n(arst_n),
        .wr_en(issue_en), .data_in(issue_uop), .rd_en(iq_pop),
        .data_out(iq_head), .empty(iq_empty), .full(iq_full)
    );

    execute u_execute (
        .uop_in(iq_head), .result(exec_result), .dest(exec_dest)
    );

    fifo #(.WIDTH(done_w), .QUEUE_DEPTH(QUEUE_DEPTH)) u_done_q (
        .clk(clk), .arst_n(arst_n),
        .wr_en(iq_pop), .data_in(dq_wr_data), .rd_en(!dq_empty),
        .data_out(dq_head), .empty(dq_empty), .full(dq_full)
    );

    retire #(.ROB_DEPTH(ROB_DEPTH)) u_retire (
        .clk(clk), .arst_n(arst_n), .valid(!dq_empty),
        .dest(dq_head[done_w-1 -: phy_addr_w]), .result(dq_head[data_w-1:0]),
        .rob_incr_tail_ptr(rob_incr_tail_ptr),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data),
        .rob_tail_ptr(rob_tail_ptr), .rob_full(rob_full)
    );

endmodule

/* tb_qu_back_end.sv */
// ==============================
// Testbench for the back end with
// vector stimulus and scoreboard
// ==============================

`timescale 1ns/1ps

module tb_qu_back_end;
    import qu_pkg::*;

    localparam int NUM_VEC    = 16;
    localparam int NUM_FIELDS = 10;
    localparam int PHASE1_LEN = 7;
    localparam int TIMEOUT    = 200 * NUM_VEC + 500;

    logic      clk;
    logic      arst_n;
    logic      schedule_en;
    logic      dispatch_en;
    opcode_t   dispatch_op;
    phy_addr_t dispatch_dest;
    rob_addr_t dispatch_rob;
    data_t     dispatch_s1_val;
    logic      dispatch_s1_rdy;
    phy_addr_t dispatch_s1_tag;
    data_t     dispatch_s2_val;
    logic      dispatch_s2_rdy;
    phy_addr_t dispatch_s2_tag;
    logic      rob_incr_tail_ptr;
    logic      dispatch_ready;
    logic      wb_en;
    phy_addr_t wb_addr;
    data_t     wb_data;
    rob_addr_t rob_tail_ptr;
    logic      rob_full;

    logic [31:0] vec_mem [NUM_VEC * NUM_FIELDS];
    logic [31:0] exp_data [64];
    bit          exp_known [64];
    int          wb_seen [64];
    int          wb_count;
    int          value_errors;
    int          other_errors;
    int          cycle_count;
    integer      seed;

    qu_back_end #(.RS_DEPTH(8), .QUEUE_DEPTH(4), .ROB_DEPTH(16)) u_dut (
        .clk(clk), .arst_n(arst_n), .schedule_en(schedule_en),
        .dispatch_en(dispatch_en), .dispatch_op(dispatch_op),
        .dispatch_dest(dispatch_dest), .dispatch_rob(dispatch_rob),
        .dispatch_s1_val(dispatch_s1_val), .dispatch_s1_rdy(dispatch_s1_rdy),
        .dispatch_s1_tag(dispatch_s1_tag), .dispatch_s2_val(dispatch_s2_val),
        .dispatch_s2_rdy(dispatch_s2_rdy), .dispatch_s2_tag(dispatch_s2_tag),
        .rob_incr_tail_ptr(rob_incr_tail_ptr), .dispatch_ready(dispatch_ready),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data),
        .rob_tail_ptr(rob_tail_ptr), .rob_full(rob_full)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            value_errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Random idle gap, then hold the op until the station accepts it
    task automatic dispatch_vec(input int n);
        int base;
        int gap;
        base = n * NUM_FIELDS;
        gap  = {$random(seed)} % 4;
        repeat (gap) @(negedge clk);
        while (!dispatch_ready) @(negedge clk);
        dispatch_op     = vec_mem[base][2:0];
        dispatch_dest   = vec_mem[base + 1][5:0];
        dispatch_rob    = vec_mem[base + 2][3:0];
        dispatch_s1_val = vec_mem[base + 3];
        dispatch_s2_val = vec_mem[base + 4];
        dispatch_s1_rdy = vec_mem[base + 5][0];
        dispatch_s2_rdy = vec_mem[base + 6][0];
        dispatch_s1_tag = vec_mem[base + 7][5:0];
        dispatch_s2_tag = vec_mem[base + 8][5:0];
        dispatch_en     = 1'b1;
        @(negedge clk);
        dispatch_en = 1'b0;
    endtask

    task automatic wait_writebacks(input int total);
        while (wb_count < total) @(negedge clk);
    endtask

    // Write-back scoreboard
    always @(negedge clk) begin
        if (arst_n && wb_en) begin
            if (!exp_known[wb_addr]) begin
                other_errors++;
                $display("Write-back hit unknown tag %h", wb_addr);
            end else begin
                if (wb_seen[wb_addr] != 0) begin
                    other_errors++;
                    $display("Tag %h was written back more than once", wb_addr);
                end
                check_value($sformatf("write-back tag %h", wb_addr), exp_data[wb_addr], wb_data);
            end
            wb_seen[wb_addr]++;
            wb_count++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT) begin
            $display("Timeout after %0d cycles with %0d write-backs seen", cycle_count, wb_count);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        int n;
        arst_n            = 1'b0;
        schedule_en       = 1'b0;
        dispatch_en       = 1'b0;
        dispatch_op       = '0;
        dispatch_dest     = '0;
        dispatch_rob      = '0;
        dispatch_s1_val   = '0;
        dispatch_s1_rdy   = 1'b0;
        dispatch_s1_tag   = '0;
        dispatch_s2_val   = '0;
        dispatch_s2_rdy   = 1'b0;
        dispatch_s2_tag   = '0;
        rob_incr_tail_ptr = 1'b0;
        wb_count          = 0;
        value_errors      = 0;
        other_errors      = 0;
        cycle_count       = 0;
        seed              = 32'he79de7b0;
        $readmemh("back_end_vectors.txt", vec_mem);
        for (n = 0; n < NUM_VEC; n++) begin
            exp_known[vec_mem[n * NUM_FIELDS + 1][5:0]] = 1'b1;
            exp_data[vec_mem[n * NUM_FIELDS + 1][5:0]]  = vec_mem[n * NUM_FIELDS + 9];
        end

        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_value("reset wb_en", 32'(0), 32'(wb_en));
        check_value("reset rob_full", 32'(0), 32'(rob_full));
        check_value("reset dispatch_ready", 32'(1), 32'(dispatch_ready));
        check_value("reset rob_tail_ptr", 32'(0), 32'(rob_tail_ptr));

        // Fill the ROB, then one pulse beyond full
        repeat (16) begin
            rob_incr_tail_ptr = 1'b1;
            @(negedge clk);
        end
        rob_incr_tail_ptr = 1'b0;
        check_value("rob full after 16", 32'(1), 32'(rob_full));
        check_value("rob tail wrapped", 32'(0), 32'(rob_tail_ptr));
        rob_incr_tail_ptr = 1'b1;
        @(negedge clk);
        rob_incr_tail_ptr = 1'b0;
        check_value("rob pulse while full", 32'(0), 32'(rob_tail_ptr));
        check_value("rob still full after extra pulse", 32'(1), 32'(rob_full));

        // Dependent ops wait in the station until scheduling starts
        for (n = 0; n < PHASE1_LEN; n++) begin
            dispatch_vec(n);
        end
        schedule_en = 1'b1;
        wait_writebacks(PHASE1_LEN);
        check_value("rob full after write-backs", 32'(0), 32'(rob_full));

        // Back-pressure with scheduling stopped
        schedule_en = 1'b0;
        for (n = PHASE1_LEN; n < NUM_VEC - 1; n++) begin
            dispatch_vec(n);
        end
        check_value("dispatch_ready with station full", 32'(0), 32'(dispatch_ready));
        repeat (6) @(negedge clk);
        check_value("dispatch_ready while stalled", 32'(0), 32'(dispatch_ready));
        check_value("write-backs while stalled", 32'(PHASE1_LEN), 32'(wb_count));
        schedule_en = 1'b1;
        dispatch_vec(NUM_VEC - 1);
        wait_writebacks(NUM_VEC);
        repeat (4) @(negedge clk);
        check_value("rob full at end", 32'(0), 32'(rob_full));
        check_value("rob tail at end", 32'(0), 32'(rob_tail_ptr));

        for (n = 0; n < 64; n++) begin
            if (exp_known[n] && wb_seen[n] != 1) begin
                other_errors++;
                $display("Tag %h was written back %0d times instead of once", n, wb_seen[n]);
            end
        end

        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* back_end_vectors.txt */
// op dest rob s1_val s2_val s1_rdy s2_rdy s1_tag s2_tag expected
// First seven carry tag dependencies, last nine are independent
0 10 0 00000005 00000007 1 1 00 00 0000000c
1 11 1 00000000 00000002 0 1 10 00 0000000a
4 12 2 00000000 000000ff 0 1 11 00 000000f5
5 13 3 00000000 00000004 0 1 12 00 00000f50
3 14 4 f0000000 0000000f 1 1 00 00 f000000f
2 15 5 00000000 00000000 0 0 14 10 0000000c
7 16 6 00000000 00000000 0 0 15 13 00000001
0 20 7 ffffffff 00000001 1 1 00 00 00000000
1 21 8 00000003 00000005 1 1 00 00 fffffffe
2 22 9 12345678 0f0f0f0f 1 1 00 00 02040608
3 23 a 12340000 00005678 1 1 00 00 12345678
4 24 b aaaaaaaa ffff0000 1 1 00 00 5555aaaa
5 25 c 00000001 00000024 1 1 00 00 00000010
6 26 d 80000000 0000001f 1 1 00 00 00000001
7 27 e fffffff0 00000002 1 1 00 00 00000001
6 28 f deadbeef 00000008 1 1 00 00 00deadbe

/* sources.f */
qu_pkg.sv
fifo.sv
res_station.sv
schedule.sv
execute.sv
retire.sv
qu_back_end.sv
tb_qu_back_end.sv
